// File: logic/fpir_add_unit.sv
// Three stage FPIR adder/subtractor top level
// Pipeline registers, significand adder and valid chain
`timescale 1ns/1ps

module fpir_add_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  input  fpir_pkg::fpir_value_t a,
  input  fpir_pkg::fpir_value_t b,
  input  logic                  sub,
  output fpir_pkg::fpir_value_t result,
  output logic                  result_valid
);
  import fpir_pkg::*;

  fpir_value_t b_eff;
  logic        bypass_d;
  fpir_value_t bypass_value_d;
  logic        bypass_s1;
  fpir_value_t bypass_value_s1;
  fpir_sum_t   operand_a;
  fpir_sum_t   operand_b;
  logic        carry_in;
  fpir_sum_t   sum;
  fpir_value_t combined;
  fpir_value_t combined_s2;
  logic        bypass_s2;
  fpir_value_t bypass_value_s2;
  logic        valid_s2;
  fpir_value_t normalized;

  // Align output and its stage 1 register
  fpir_aligned_if aligned_d ();
  fpir_aligned_if aligned_q ();

  // ************************************************************************
  // Stage 1 special detection and alignment, in parallel
  // ************************************************************************

  // a - b is a + (-b)
  always_comb begin
    b_eff      = b;
    b_eff.sign = b.sign ^ sub;
  end

  fpir_special u_special (
    .a            (a),
    .b            (b_eff),
    .bypass       (bypass_d),
    .bypass_value (bypass_value_d)
  );

  fpir_align u_align (
    .a        (a),
    .b        (b),
    .sub      (sub),
    .in_valid (in_valid),
    .aligned  (aligned_d)
  );

  // ************************************************************************
  // Stage 2 sign handling around the significand adder
  // ************************************************************************

  fpir_sign_combine u_sign_combine (
    .aligned   (aligned_q),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .carry_in  (carry_in),
    .sum       (sum),
    .combined  (combined)
  );

  assign sum = operand_a + operand_b + {{(bw_sum - 1){1'b0}}, carry_in};

  // ************************************************************************
  // Stage 3 normalization and bypass select
  // ************************************************************************

  fpir_normalize u_normalize (
    .combined   (combined_s2),
    .normalized (normalized)
  );

  // Valid chain, one bit per stage
  always_ff @(posedge clk) begin
    if (reset) begin
      aligned_q.valid <= 1'b0;
      valid_s2        <= 1'b0;
      result_valid    <= 1'b0;
    end else begin
      aligned_q.valid <= aligned_d.valid;
      valid_s2        <= aligned_q.valid;
      result_valid    <= valid_s2;
    end
  end

  // Data path registers
  always_ff @(posedge clk) begin
    aligned_q.big    <= aligned_d.big;
    aligned_q.little <= aligned_d.little;
    aligned_q.sub    <= aligned_d.sub;
    bypass_s1        <= bypass_d;
    bypass_value_s1  <= bypass_value_d;
    combined_s2      <= combined;
    bypass_s2        <= bypass_s1;
    bypass_value_s2  <= bypass_value_s1;
    // Special cases skip the arithmetic result
    result           <= bypass_s2 ? bypass_value_s2 : normalized;
  end

endmodule

// File: logic/fpir_align.sv
// Exponent compare and operand ordering by magnitude
// Right shift of the smaller significand with sticky collection
`timescale 1ns/1ps

module fpir_align (
  input  fpir_pkg::fpir_value_t a,
  input  fpir_pkg::fpir_value_t b,
  input  logic                  sub,
  input  logic                  in_valid,
  fpir_aligned_if.source        aligned
);
  import fpir_pkg::*;

  fpir_value_t                     b_eff;
  logic                            a_larger;
  fpir_value_t                     big_op;
  fpir_value_t                     little_op;
  logic [bw_exponent:0]            exp_diff;
  logic [bw_shift-1:0]             shift_amt;
  logic [2*bw_significand_ext-1:0] shifted;
  logic                            sticky;
  fpir_value_t                     little_aligned;

  // Subtraction flips the sign of b
  always_comb begin
    b_eff      = b;
    b_eff.sign = b.sign ^ sub;
  end

  // ************************************************************************
  // Ordering
  // ************************************************************************

  // Exponent decides first, then significand with guard on a tie
  // a wins a full tie
  assign a_larger = ($signed(a.exponent) > $signed(b_eff.exponent)) ||
                    (($signed(a.exponent) == $signed(b_eff.exponent)) &&
                     ({a.significand, a.guard} >= {b_eff.significand, b_eff.guard}));

  assign big_op    = a_larger ? a : b_eff;
  assign little_op = a_larger ? b_eff : a;

  // ************************************************************************
  // Alignment shift
  // ************************************************************************

  // Sign extended difference, never negative after ordering
  assign exp_diff = {big_op.exponent[bw_exponent-1], big_op.exponent} -
                    {little_op.exponent[bw_exponent-1], little_op.exponent};

  // Beyond the full width only the sticky bit is left
  assign shift_amt = (exp_diff >= (bw_exponent + 1)'(bw_significand_ext)) ?
                     bw_shift'(bw_significand_ext) : exp_diff[bw_shift-1:0];

  // Lower half catches every bit that falls off the end
  assign shifted = {little_op.significand, little_op.guard, {bw_significand_ext{1'b0}}}
                   >> shift_amt;

  assign sticky = |shifted[bw_significand_ext-1:0];

  always_comb begin
    little_aligned          = little_op;
    little_aligned.exponent = big_op.exponent;
    {little_aligned.significand, little_aligned.guard} =
      shifted[2*bw_significand_ext-1:bw_significand_ext];
    // Sticky folds into the lowest guard bit
    little_aligned.guard[0] = shifted[bw_significand_ext] | sticky;
  end

  assign aligned.big    = big_op;
  assign aligned.little = little_aligned;
  assign aligned.sub    = a.sign ^ b_eff.sign;
  assign aligned.valid  = in_valid;

endmodule

// File: logic/fpir_aligned_if.sv
// Aligned operand pair passed from the align stage to the sign stage
`timescale 1ns/1ps

interface fpir_aligned_if;

  // Larger magnitude operand, untouched
  fpir_pkg::fpir_value_t big;

  // Smaller operand, already shifted to the exponent of big
  // sticky bit sits in guard[0]
  fpir_pkg::fpir_value_t little;

  // Effective operation, high when the operand signs differ
  logic sub;

  // Live item in this cycle
  logic valid;

  modport source (
    output big,
    output little,
    output sub,
    output valid
  );

  modport sink (
    input big,
    input little,
    input sub,
    input valid
  );

endinterface

// File: logic/fpir_normalize.sv
// Leading zero count over significand and guard
// Left shift normalization, exponent adjust and zero detection
`timescale 1ns/1ps

module fpir_normalize (
  input  fpir_pkg::fpir_value_t combined,
  output fpir_pkg::fpir_value_t normalized
);
  import fpir_pkg::*;

  logic [bw_significand_ext-1:0] mag;
  logic [bw_shift-1:0]           lz_count;
  logic [bw_significand_ext-1:0] mag_shifted;
  logic                          is_zero;

  assign mag = {combined.significand, combined.guard};

  // ************************************************************************
  // Leading zero count
  // ************************************************************************

  // Scan from the top and stop counting at the first one
  // An all-zero magnitude counts the full width
  always_comb begin
    logic found;
    found    = 1'b0;
    lz_count = '0;
    for (int i = bw_significand_ext - 1; i >= 0; i--) begin
      if (!found) begin
        if (mag[i]) begin
          found = 1'b1;
        end else begin
          lz_count = lz_count + 1'b1;
        end
      end
    end
  end

  // ************************************************************************
  // Shift and result build
  // ************************************************************************

  // Brings the leading one to the top bit
  assign mag_shifted = mag << lz_count;

  assign is_zero = (mag == '0);

  always_comb begin
    if (is_zero) begin
      // Exact cancellation gives a positive zero
      normalized      = '0;
      normalized.kind = fpir_zero;
    end else begin
      normalized.kind     = combined.kind;
      normalized.sign     = combined.sign;
      // Exponent drops by one for every position shifted
      normalized.exponent = combined.exponent - bw_exponent'(lz_count);
      {normalized.significand, normalized.guard} = mag_shifted;
      normalized.overflow = '0;
    end
  end

endmodule

// File: logic/fpir_pkg.sv
// FPIR field widths and value type codes
// Packed FPIR value and adder operand types
package fpir_pkg;

  // ************************************************************************
  // Field widths
  // ************************************************************************

  localparam int bw_fpir_type = 2;
  localparam int bw_exponent = 10;
  localparam int bw_significand = 24;
  localparam int bw_guard = 3;
  localparam int bw_overflow = 1;

  // Significand with guard bits appended below
  localparam int bw_significand_ext = bw_significand + bw_guard;

  // One extra bit on top for carry or sign of the raw sum
  localparam int bw_sum = bw_significand_ext + 1;

  // Shift counts run from 0 up to bw_significand_ext inclusive
  localparam int bw_shift = $clog2(bw_significand_ext + 1);

  // ************************************************************************
  // Value class
  // ************************************************************************

  typedef enum logic [bw_fpir_type-1:0] {
    fpir_normal = 2'd0,
    fpir_zero   = 2'd1,
    fpir_inf    = 2'd2,
    fpir_nan    = 2'd3
  } fpir_type_t;

  // ************************************************************************
  // FPIR value, 41 bits, most significant field first
  // ************************************************************************

  typedef struct packed {
    fpir_type_t                     kind;
    logic                           sign;
    // Unbiased, two's complement
    logic signed [bw_exponent-1:0]  exponent;
    // Leading one is explicit at the top
    logic [bw_significand-1:0]      significand;
    logic [bw_guard-1:0]            guard;
    // Set when the exponent increment wraps
    logic [bw_overflow-1:0]         overflow;
  } fpir_value_t;

  // Adder operands and raw sum
  typedef logic [bw_sum-1:0] fpir_sum_t;

endpackage

// File: logic/fpir_sign_combine.sv
// Adder operand build from operand signs by conditional complement
// Raw sum decode back into sign and magnitude
`timescale 1ns/1ps

module fpir_sign_combine (
  fpir_aligned_if.sink          aligned,
  output fpir_pkg::fpir_sum_t   operand_a,
  output fpir_pkg::fpir_sum_t   operand_b,
  output logic                  carry_in,
  input  fpir_pkg::fpir_sum_t   sum,
  output fpir_pkg::fpir_value_t combined
);
  import fpir_pkg::*;

  logic [bw_significand_ext-1:0] big_mag;
  logic [bw_significand_ext-1:0] little_mag;
  logic                          big_neg;
  logic                          little_neg;
  logic                          carry_out;
  logic                          negate;
  fpir_sum_t                     sum_neg;
  logic [bw_significand_ext-1:0] mag;
  logic [bw_exponent:0]          exp_inc;

  assign big_mag    = {aligned.big.significand, aligned.big.guard};
  assign little_mag = {aligned.little.significand, aligned.little.guard};

  // ************************************************************************
  // Adder operands
  // ************************************************************************

  // Only the negative side of a mixed-sign pair is complemented
  // With equal signs both go in as plain magnitudes
  assign big_neg    = aligned.sub & aligned.big.sign;
  assign little_neg = aligned.sub & aligned.little.sign;

  assign operand_a = big_neg    ? ~{1'b0, big_mag}    : {1'b0, big_mag};
  assign operand_b = little_neg ? ~{1'b0, little_mag} : {1'b0, little_mag};

  // +1 turns the one's complement into two's complement
  assign carry_in = big_neg | little_neg;

  // ************************************************************************
  // Sum decode
  // ************************************************************************

  // Top bit is a carry for equal signs and a sign bit otherwise
  assign carry_out = ~aligned.sub & sum[bw_sum-1];
  assign negate    = aligned.sub & sum[bw_sum-1];

  assign sum_neg = ~sum + 1'b1;

  always_comb begin
    if (carry_out) begin
      // Carry out, drop the lowest bit
      mag = sum[bw_sum-1:1];
    end else if (negate) begin
      mag = sum_neg[bw_significand_ext-1:0];
    end else begin
      mag = sum[bw_significand_ext-1:0];
    end
  end

  // Exponent bump on carry out, sign extended to catch the wrap
  assign exp_inc = {aligned.big.exponent[bw_exponent-1], aligned.big.exponent} +
                   {{bw_exponent{1'b0}}, carry_out};

  always_comb begin
    combined.kind     = fpir_normal;
    // Shared sign for equal signs, sum sign for mixed signs
    combined.sign     = aligned.sub ? negate : aligned.big.sign;
    combined.exponent = exp_inc[bw_exponent-1:0];
    {combined.significand, combined.guard} = mag;
    // Signed overflow when the two top bits disagree
    combined.overflow = exp_inc[bw_exponent] ^ exp_inc[bw_exponent-1];
  end

endmodule

// File: logic/fpir_special.sv
// Operand classification for zero, infinity and nan
// Bypass flag and bypass result for the special cases
`timescale 1ns/1ps

module fpir_special (
  input  fpir_pkg::fpir_value_t a,
  input  fpir_pkg::fpir_value_t b,
  output logic                  bypass,
  output fpir_pkg::fpir_value_t bypass_value
);
  import fpir_pkg::*;

  logic a_nan;
  logic b_nan;
  logic a_inf;
  logic b_inf;
  logic a_zero;
  logic b_zero;
  fpir_value_t nan_value;
  fpir_value_t zero_value;

  assign a_nan  = (a.kind == fpir_nan);
  assign b_nan  = (b.kind == fpir_nan);
  assign a_inf  = (a.kind == fpir_inf);
  assign b_inf  = (b.kind == fpir_inf);
  assign a_zero = (a.kind == fpir_zero);
  assign b_zero = (b.kind == fpir_zero);

  // Canonical nan, all payload fields cleared
  always_comb begin
    nan_value      = '0;
    nan_value.kind = fpir_nan;
  end

  // Zero keeps a negative sign only when both inputs are negative zeros
  always_comb begin
    zero_value      = '0;
    zero_value.kind = fpir_zero;
    zero_value.sign = a.sign & b.sign;
  end

  // Priority follows the order of the rules
  always_comb begin
    bypass       = 1'b1;
    bypass_value = a;
    if (a_nan || b_nan) begin
      bypass_value = nan_value;
    end else if (a_inf && b_inf && (a.sign != b.sign)) begin
      // inf - inf
      bypass_value = nan_value;
    end else if (a_inf) begin
      bypass_value = a;
    end else if (b_inf) begin
      bypass_value = b;
    end else if (a_zero && b_zero) begin
      bypass_value = zero_value;
    end else if (a_zero) begin
      bypass_value = b;
    end else if (b_zero) begin
      bypass_value = a;
    end else begin
      // Both normal, arithmetic path owns the result
      bypass = 1'b0;
    end
  end

endmodule

// File: project.f
logic/fpir_pkg.sv
logic/fpir_aligned_if.sv
logic/fpir_special.sv
logic/fpir_align.sv
logic/fpir_sign_combine.sv
logic/fpir_normalize.sv
logic/fpir_add_unit.sv
testbench/fpir_add_unit_properties.sv
testbench/tb_fpir_add_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the FPIR adder testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --assert --timing -Wno-fatal \
  --top-module tb_fpir_add_unit -f project.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$log_file"; then
  exit 0
fi
echo "Pass message not found in $log_file"
exit 1

// File: testbench/fpir_add_unit_properties.sv
// Concurrent checks on result valid timing and result class
// Bound into the FPIR adder top level
`timescale 1ns/1ps

module fpir_add_unit_properties (
  input logic                  clk,
  input logic                  reset,
  input logic                  in_valid,
  input logic                  result_valid,
  input fpir_pkg::fpir_value_t result
);
  import fpir_pkg::*;

  // Synchronous reset clears the valid chain
  a_reset_valid: assert property (@(posedge clk) reset |=> !result_valid)
    else $error("result_valid high in the cycle after reset");

  // Three cycle latency once the chain holds no reset cycles
  a_valid_latency: assert property (@(posedge clk) disable iff (reset)
    (!$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3)) |->
    (result_valid == $past(in_valid, 3)))
    else $error("result_valid does not follow in_valid three cycles later");

  // Normal results carry an explicit leading one
  a_normal_leading_one: assert property (@(posedge clk) disable iff (reset)
    (result_valid && (result.kind == fpir_normal)) |->
    result.significand[bw_significand-1])
    else $error("Normal result with a zero leading significand bit");

endmodule

bind fpir_add_unit fpir_add_unit_properties u_properties (
  .clk          (clk),
  .reset        (reset),
  .in_valid     (in_valid),
  .result_valid (result_valid),
  .result       (result)
);

// File: testbench/tb_fpir_add_unit.sv
// Testbench for the FPIR adder/subtractor top level
// LCG stimulus, bit level reference model, output checks and watchdog
`timescale 1ns/1ps

module tb_fpir_add_unit;
  import fpir_pkg::*;

  localparam int clk_period = 8;
  localparam int reset_cycles = 5;
  localparam int max_directed_items = 100;
  localparam int num_random_slots = 400;
  localparam int watchdog_cycles = max_directed_items + num_random_slots + reset_cycles + 20;
  // Weight of the leading significand bit within significand and guard
  localparam longint ext_one = longint'(1) << (bw_significand_ext - 1);

  logic        clk = 1'b0;
  logic        reset;
  logic        in_valid;
  fpir_value_t a;
  fpir_value_t b;
  logic        sub;
  fpir_value_t result;
  logic        result_valid;

  logic [31:0] lcg_state = 32'h5485;
  fpir_value_t expected_q[$];
  logic        valid_d1;
  logic        valid_d2;
  logic        exp_valid;
  int          value_errors = 0;
  int          flag_errors = 0;
  int          other_errors = 0;

  fpir_add_unit u_dut (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .a            (a),
    .b            (b),
    .sub          (sub),
    .result       (result),
    .result_valid (result_valid)
  );

  always #(clk_period / 2) clk = ~clk;

  // ************************************************************************
  // Random numbers and operand builders
  // ************************************************************************

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic fpir_value_t make_normal(input logic sign, input int exponent,
                                              input logic [23:0] sig, input logic [2:0] guard);
    fpir_value_t v;
    v             = '0;
    v.kind        = fpir_normal;
    v.sign        = sign;
    v.exponent    = bw_exponent'(exponent);
    v.significand = sig;
    v.guard       = guard;
    return v;
  endfunction

  function automatic fpir_value_t make_special(input fpir_type_t kind, input logic sign);
    fpir_value_t v;
    v      = '0;
    v.kind = kind;
    v.sign = sign;
    return v;
  endfunction

  // Low LCG bits repeat quickly so only upper bits are used
  function automatic fpir_value_t random_normal(input int exp_lo, input int exp_hi);
    logic [31:0] r1;
    logic [31:0] r2;
    r1 = next_random();
    r2 = next_random();
    return make_normal(r1[31], exp_lo + int'(r1[23:8]) % (exp_hi - exp_lo + 1),
                       {1'b1, r2[31:9]}, r2[8:6]);
  endfunction

  function automatic fpir_value_t random_special();
    logic [31:0] r;
    r = next_random();
    if (r[30:29] == 2'd0) begin
      return random_normal(-100, 100);
    end
    return make_special(fpir_type_t'(r[30:29]), r[31]);
  endfunction

  // ************************************************************************
  // Reference model
  // ************************************************************************

  // Right shift with every dropped bit ORed into bit 0
  function automatic longint shift_with_sticky(input longint m, input int d);
    longint kept;
    logic   sticky;
    if (d >= bw_significand_ext) begin
      return (m != 0) ? longint'(1) : longint'(0);
    end
    kept   = m >> d;
    sticky = ((m & ((longint'(1) << d) - 1)) != 0);
    return kept | longint'(sticky);
  endfunction

  function automatic fpir_value_t expected_sum(input fpir_value_t x, input fpir_value_t y,
                                               input logic s);
    fpir_value_t yn;
    fpir_value_t r;
    longint      mx;
    longint      my;
    longint      total;
    longint      mag;
    int          ex;
    int          ey;
    int          e;
    yn      = y;
    yn.sign = y.sign ^ s;
    r       = '0;
    // First matching special rule wins
    if ((x.kind == fpir_nan) || (yn.kind == fpir_nan)) begin
      r.kind = fpir_nan;
      return r;
    end
    if ((x.kind == fpir_inf) && (yn.kind == fpir_inf) && (x.sign != yn.sign)) begin
      r.kind = fpir_nan;
      return r;
    end
    if (x.kind == fpir_inf) return x;
    if (yn.kind == fpir_inf) return yn;
    if ((x.kind == fpir_zero) && (yn.kind == fpir_zero)) begin
      r.kind = fpir_zero;
      r.sign = x.sign & yn.sign;
      return r;
    end
    if (x.kind == fpir_zero) return yn;
    if (yn.kind == fpir_zero) return x;
    // Smaller exponent moves to the larger one
    mx = longint'({x.significand, x.guard});
    my = longint'({yn.significand, yn.guard});
    ex = int'($signed(x.exponent));
    ey = int'($signed(yn.exponent));
    if (ex >= ey) begin
      e  = ex;
      my = shift_with_sticky(my, ex - ey);
    end else begin
      e  = ey;
      mx = shift_with_sticky(mx, ey - ex);
    end
    // Exact signed sum of the aligned magnitudes
    total  = (x.sign ? -mx : mx) + (yn.sign ? -my : my);
    r.sign = (total < 0);
    mag    = (total < 0) ? -total : total;
    // Carry out drops the lowest bit
    if (mag >= (ext_one << 1)) begin
      mag = mag >> 1;
      e   = e + 1;
    end
    if (mag == 0) begin
      r      = '0;
      r.kind = fpir_zero;
      return r;
    end
    while (mag < ext_one) begin
      mag = mag << 1;
      e   = e - 1;
    end
    r.kind                   = fpir_normal;
    r.exponent               = bw_exponent'(e);
    {r.significand, r.guard} = bw_significand_ext'(mag);
    r.overflow               = '0;
    return r;
  endfunction

  // ************************************************************************
  // Checks
  // ************************************************************************

  task automatic compare_field(input string name, input logic [31:0] actual,
                               input logic [31:0] want);
    if (actual !== want) begin
      $display("Mismatch at %0t: %s actual 0x%0h expected 0x%0h", $time, name, actual, want);
      value_errors++;
    end
  endtask

  task automatic compare_value(input string name, input fpir_value_t actual,
                               input fpir_value_t want);
    compare_field({name, ".kind"}, 32'(actual.kind), 32'(want.kind));
    compare_field({name, ".sign"}, 32'(actual.sign), 32'(want.sign));
    compare_field({name, ".exponent"}, 32'(actual.exponent), 32'(want.exponent));
    compare_field({name, ".significand"}, 32'(actual.significand), 32'(want.significand));
    compare_field({name, ".guard"}, 32'(actual.guard), 32'(want.guard));
    compare_field({name, ".overflow"}, 32'(actual.overflow), 32'(want.overflow));
  endtask

  task automatic compare_flag(input string name, input logic actual, input logic want);
    if (actual !== want) begin
      $display("Mismatch at %0t: %s actual %b expected %b", $time, name, actual, want);
      flag_errors++;
    end
  endtask

  // Expected valid runs three accepted edges behind in_valid
  always @(posedge clk) begin
    if (reset) begin
      valid_d1  <= 1'b0;
      valid_d2  <= 1'b0;
      exp_valid <= 1'b0;
    end else begin
      valid_d1  <= in_valid;
      valid_d2  <= valid_d1;
      exp_valid <= valid_d2;
    end
  end

  // Outputs are stable away from the rising edge
  always @(negedge clk) begin : check_outputs
    fpir_value_t want;
    compare_flag("result_valid", result_valid, exp_valid);
    if (result_valid === 1'b1) begin
      if (expected_q.size() == 0) begin
        $display("Result at %0t arrived with no expected value queued", $time);
        other_errors++;
      end else begin
        want = expected_q.pop_front();
        compare_value("result", result, want);
      end
    end
  end

  // ************************************************************************
  // Stimulus
  // ************************************************************************

  task automatic apply_item(input fpir_value_t x, input fpir_value_t y, input logic s);
    @(posedge clk);
    a        <= x;
    b        <= y;
    sub      <= s;
    in_valid <= 1'b1;
    expected_q.push_back(expected_sum(x, y, s));
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // Back to back items with no gaps
  task automatic run_directed();
    fpir_value_t x;
    fpir_value_t ops[6];
    // Like signs with carry out
    apply_item(make_normal(1'b0, 10, 24'hc00000, 3'b101),
               make_normal(1'b0, 10, 24'ha00001, 3'b011), 1'b0);
    apply_item(make_normal(1'b1, -7, 24'hffffff, 3'b111),
               make_normal(1'b1, -9, 24'hf00000, 3'b001), 1'b0);
    // Unlike signs directly and through sub
    apply_item(make_normal(1'b0, 5, 24'h800000, 3'b000),
               make_normal(1'b0, 3, 24'hc00000, 3'b000), 1'b1);
    apply_item(make_normal(1'b0, 2, 24'h900000, 3'b010),
               make_normal(1'b1, 2, 24'h8fffff, 3'b000), 1'b0);
    apply_item(make_normal(1'b1, -4, 24'ha5a5a5, 3'b100),
               make_normal(1'b1, 0, 24'h812345, 3'b001), 1'b1);
    // a minus a
    x = random_normal(-50, 50);
    apply_item(x, x, 1'b1);
    x = random_normal(-50, 50);
    apply_item(x, x, 1'b1);
    // Exponent gaps around and beyond the field width
    apply_item(make_normal(1'b0, 60, 24'h800000, 3'b000),
               make_normal(1'b0, 30, 24'hffffff, 3'b111), 1'b0);
    apply_item(make_normal(1'b1, 0, 24'hc00000, 3'b000),
               make_normal(1'b0, -28, 24'h800001, 3'b000), 1'b1);
    apply_item(make_normal(1'b0, 27, 24'h800000, 3'b000),
               make_normal(1'b1, 0, 24'h800000, 3'b001), 1'b0);
    apply_item(make_normal(1'b0, -90, 24'habcdef, 3'b010),
               make_normal(1'b1, 90, 24'h800000, 3'b000), 1'b0);
    // Every pair of special classes with both operations
    ops[0] = make_special(fpir_nan, 1'b0);
    ops[1] = make_special(fpir_inf, 1'b0);
    ops[2] = make_special(fpir_inf, 1'b1);
    ops[3] = make_special(fpir_zero, 1'b0);
    ops[4] = make_special(fpir_zero, 1'b1);
    ops[5] = random_normal(-20, 20);
    for (int i = 0; i < 6; i++) begin
      for (int j = 0; j < 6; j++) begin
        apply_item(ops[i], ops[j], 1'b0);
        apply_item(ops[i], ops[j], 1'b1);
      end
    end
  endtask

  // One slot per cycle with about one in eight left idle
  task automatic run_random();
    logic [31:0] r;
    fpir_value_t x;
    fpir_value_t y;
    logic        s;
    for (int n = 0; n < num_random_slots; n++) begin
      r = next_random();
      s = r[25];
      if (r[31:29] == 3'd0) begin
        idle_cycle();
      end else begin
        case (r[28:26])
          3'd0: begin
            x = random_special();
            y = random_normal(-100, 100);
          end
          3'd1: begin
            x = random_normal(-100, 100);
            y = random_special();
          end
          3'd2: begin
            x = random_normal(-100, 100);
            y = x;
            s = 1'b1;
          end
          3'd3: begin
            x = random_normal(40, 100);
            y = random_normal(-100, 10);
          end
          default: begin
            x = random_normal(-6, 6);
            y = random_normal(-6, 6);
          end
        endcase
        apply_item(x, y, s);
      end
    end
  endtask

  initial begin : watchdog
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired at %0t before the test sequence completed", $time);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    reset    = 1'b1;
    // Items offered during reset must never reach the output
    in_valid = 1'b1;
    a        = '0;
    b        = '0;
    sub      = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset    <= 1'b0;
    in_valid <= 1'b0;
    run_directed();
    run_random();
    idle_cycle();
    // Latency is fixed at three, so this covers the last item
    repeat (6) @(posedge clk);
    if (expected_q.size() != 0) begin
      $display("%0d expected results never appeared on the output", expected_q.size());
      other_errors++;
    end
    $display("Errors: value %0d, valid %0d, other %0d", value_errors, flag_errors, other_errors);
    if ((value_errors + flag_errors + other_errors) == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
